// ==== rtl/iq_pkg.sv ====
`default_nettype none

package iq_pkg;

    // physical destination tag
    typedef logic [3:0] tag_t;

    // operand and result word
    typedef logic [15:0] data_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_e;

    // value is valid once ready is set, otherwise tag names the producer
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } operand_t;

    typedef struct packed {
        alu_op_e  op;
        tag_t     dst;
        operand_t src1;
        operand_t src2;
    } iq_entry_t;

    // one broadcast per lane
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } wake_t;

    localparam int DEF_QUEUE_LEN = 8;
    localparam int DEF_ISSUE_WIDTH = 2;

endpackage

`default_nettype wire

// ==== rtl/issue_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface issue_if #(
    parameter int ISSUE_WIDTH = iq_pkg::DEF_ISSUE_WIDTH
);
    import iq_pkg::*;

    logic    [ISSUE_WIDTH-1:0] valid;
    alu_op_e [ISSUE_WIDTH-1:0] op;
    tag_t    [ISSUE_WIDTH-1:0] dst;
    data_t   [ISSUE_WIDTH-1:0] a;
    data_t   [ISSUE_WIDTH-1:0] b;

    // queue side
    modport issue (output valid, op, dst, a, b);

    // alu side
    modport exec (input valid, op, dst, a, b);

endinterface

`default_nettype wire

// ==== rtl/dispatch_wb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dispatch_wb #(
    parameter int QUEUE_LEN = iq_pkg::DEF_QUEUE_LEN
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           wb_cyc,
    input  wire logic                           wb_stb,
    input  wire logic                           wb_we,
    input  wire logic [1:0]                     wb_adr,
    input  wire logic [31:0]                    wb_dat_w,
    output logic      [31:0]                    wb_dat_r,
    output logic                                wb_ack,
    output logic                                push_valid,
    output iq_pkg::iq_entry_t                   push_entry,
    input  wire logic                           push_ready,
    input  wire logic [$clog2(QUEUE_LEN+1)-1:0] occupancy
);
    import iq_pkg::*;

    localparam logic [1:0] ADR_SRC1 = 2'd0;
    localparam logic [1:0] ADR_SRC2 = 2'd1;
    localparam logic [1:0] ADR_CMD  = 2'd2;
    localparam logic [1:0] ADR_STAT = 2'd3;

    operand_t src1_q;
    operand_t src2_q;
    logic     req;
    logic     cmd_req;

    // a transfer is seen once, ack masks the cycle it completes in
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign cmd_req = req && wb_we && (wb_adr == ADR_CMD);

    assign push_valid = cmd_req;

    always_comb begin
        push_entry.op = alu_op_e'(wb_dat_w[6:4]);
        push_entry.dst = tag_t'(wb_dat_w[3:0]);
        push_entry.src1 = src1_q;
        push_entry.src2 = src2_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else if (cmd_req) begin
            // command waits for the queue
            wb_ack <= push_ready;
        end else begin
            wb_ack <= req;
        end
    end

    // staged sources
    always_ff @(posedge clk) begin
        if (req && wb_we && wb_adr == ADR_SRC1) begin
            src1_q <= operand_t'(wb_dat_w[20:0]);
        end
        if (req && wb_we && wb_adr == ADR_SRC2) begin
            src2_q <= operand_t'(wb_dat_w[20:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            case (wb_adr)
                ADR_SRC1: wb_dat_r <= {11'd0, src1_q};
                ADR_SRC2: wb_dat_r <= {11'd0, src2_q};
                ADR_STAT: wb_dat_r <= 32'(occupancy);
                default:  wb_dat_r <= 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_queue #(
    parameter int QUEUE_LEN   = iq_pkg::DEF_QUEUE_LEN,
    parameter int ISSUE_WIDTH = iq_pkg::DEF_ISSUE_WIDTH
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              flush,
    input  wire logic                              push_valid,
    input  wire iq_pkg::iq_entry_t                 push_entry,
    output logic                                   push_ready,
    input  wire iq_pkg::wake_t [ISSUE_WIDTH-1:0]   wake,
    issue_if.issue                                 iss,
    output logic                                   full,
    output logic [$clog2(QUEUE_LEN+1)-1:0]         occupancy
);
    import iq_pkg::*;

    localparam int OCC_W = $clog2(QUEUE_LEN+1);

    iq_entry_t            q     [QUEUE_LEN];
    iq_entry_t            q_n   [QUEUE_LEN];
    logic [OCC_W-1:0]     count;
    logic [OCC_W-1:0]     count_n;
    logic                 accept;
    logic [ISSUE_WIDTH-1:0] lane_valid;
    iq_entry_t            lane_e [ISSUE_WIDTH];

    // mark a source ready when its producer broadcasts
    function automatic operand_t wake_operand(
        operand_t                      src,
        wake_t [ISSUE_WIDTH-1:0]       wk
    );
        operand_t res;
        res = src;
        for (int w = 0; w < ISSUE_WIDTH; w++) begin
            if (wk[w].valid && !res.ready && res.tag == wk[w].tag) begin
                res.ready = 1'b1;
                res.value = wk[w].data;
            end
        end
        return res;
    endfunction

    always_comb begin
        iq_entry_t woken [QUEUE_LEN];
        iq_entry_t inc;
        int        n;
        int        k;

        // wakeup first on stored entries and the incoming one
        for (int j = 0; j < QUEUE_LEN; j++) begin
            woken[j] = q[j];
            woken[j].src1 = wake_operand(q[j].src1, wake);
            woken[j].src2 = wake_operand(q[j].src2, wake);
        end
        inc = push_entry;
        inc.src1 = wake_operand(push_entry.src1, wake);
        inc.src2 = wake_operand(push_entry.src2, wake);

        q_n = q;
        n = 0;
        k = 0;
        lane_valid = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            lane_e[l] = '0;
        end

        // oldest ready entries take the lanes while the rest move to the head
        for (int j = 0; j < QUEUE_LEN; j++) begin
            if (j < int'(count)) begin
                if (woken[j].src1.ready && woken[j].src2.ready && n < ISSUE_WIDTH) begin
                    lane_valid[n] = 1'b1;
                    lane_e[n] = woken[j];
                    n = n + 1;
                end else begin
                    q_n[k] = woken[j];
                    k = k + 1;
                end
            end
        end

        // incoming entry issues at once or goes to the tail
        accept = 1'b0;
        if (n < ISSUE_WIDTH && inc.src1.ready && inc.src2.ready) begin
            accept = 1'b1;
            if (push_valid && !flush) begin
                lane_valid[n] = 1'b1;
                lane_e[n] = inc;
            end
        end else if (k < QUEUE_LEN) begin
            accept = 1'b1;
            if (push_valid && !flush) begin
                q_n[k] = inc;
                k = k + 1;
            end
        end

        count_n = OCC_W'(k);
    end

    // nothing leaves or enters while flushing
    assign push_ready = accept && !flush;

    assign iss.valid = lane_valid & {ISSUE_WIDTH{!flush}};

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_lane
        assign iss.op[l] = lane_e[l].op;
        assign iss.dst[l] = lane_e[l].dst;
        assign iss.a[l] = lane_e[l].src1.value;
        assign iss.b[l] = lane_e[l].src2.value;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            count <= '0;
        end else begin
            count <= count_n;
        end
    end

    always_ff @(posedge clk) begin
        q <= q_n;
    end

    assign full = (count == OCC_W'(QUEUE_LEN));
    assign occupancy = count;

endmodule

`default_nettype wire

// ==== rtl/alu_lanes.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_lanes #(
    parameter int ISSUE_WIDTH = iq_pkg::DEF_ISSUE_WIDTH
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    issue_if.exec                            iss,
    output iq_pkg::wake_t [ISSUE_WIDTH-1:0]  wake
);
    import iq_pkg::*;

    logic [ISSUE_WIDTH-1:0] valid_q;
    tag_t                   tag_q [ISSUE_WIDTH];
    data_t                  res_q [ISSUE_WIDTH];

    function automatic data_t alu_calc(alu_op_e op, data_t a, data_t b);
        data_t r;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            // shift amount from the low nibble
            ALU_SLL: r = a << b[3:0];
            default: r = '0;
        endcase
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= iss.valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            tag_q[l] <= iss.dst[l];
            res_q[l] <= alu_calc(iss.op[l], iss.a[l], iss.b[l]);
        end
    end

    // broadcast back to the queue
    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_wake
        assign wake[l].valid = valid_q[l];
        assign wake[l].tag = tag_q[l];
        assign wake[l].data = res_q[l];
    end

endmodule

`default_nettype wire

// ==== rtl/issue_cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_cluster #(
    parameter int QUEUE_LEN   = iq_pkg::DEF_QUEUE_LEN,
    parameter int ISSUE_WIDTH = iq_pkg::DEF_ISSUE_WIDTH
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        flush,
    input  wire logic                        wb_cyc,
    input  wire logic                        wb_stb,
    input  wire logic                        wb_we,
    input  wire logic [1:0]                  wb_adr,
    input  wire logic [31:0]                 wb_dat_w,
    output logic      [31:0]                 wb_dat_r,
    output logic                             wb_ack,
    output logic                             full,
    output logic [ISSUE_WIDTH-1:0]           done_valid,
    output iq_pkg::tag_t [ISSUE_WIDTH-1:0]   done_tag,
    output iq_pkg::data_t [ISSUE_WIDTH-1:0]  done_data
);
    import iq_pkg::*;

    localparam int OCC_W = $clog2(QUEUE_LEN+1);

    logic                    push_valid;
    iq_entry_t               push_entry;
    logic                    push_ready;
    logic [OCC_W-1:0]        occupancy;
    wake_t [ISSUE_WIDTH-1:0] wake;

    issue_if #(.ISSUE_WIDTH(ISSUE_WIDTH)) iss_if ();

    dispatch_wb #(.QUEUE_LEN(QUEUE_LEN)) dispatch_wb_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .push_valid (push_valid),
        .push_entry (push_entry),
        .push_ready (push_ready),
        .occupancy  (occupancy)
    );

    issue_queue #(.QUEUE_LEN(QUEUE_LEN), .ISSUE_WIDTH(ISSUE_WIDTH)) issue_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .push_valid (push_valid),
        .push_entry (push_entry),
        .push_ready (push_ready),
        .wake       (wake),
        .iss        (iss_if.issue),
        .full       (full),
        .occupancy  (occupancy)
    );

    alu_lanes #(.ISSUE_WIDTH(ISSUE_WIDTH)) alu_lanes_i (
        .clk   (clk),
        .rst_n (rst_n),
        .iss   (iss_if.exec),
        .wake  (wake)
    );

    // completion ports mirror the wake bus
    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_done
        assign done_valid[l] = wake[l].valid;
        assign done_tag[l] = wake[l].tag;
        assign done_data[l] = wake[l].data;
    end

endmodule

`default_nettype wire

// ==== tb/issue_cluster_vectors.svh ====
`ifndef ISSUE_CLUSTER_VECTORS_SVH
`define ISSUE_CLUSTER_VECTORS_SVH

// flag bits {acked, completes, flush_after, read_stat}
localparam int F_ACK = 3;
localparam int F_DONE = 2;
localparam int F_FLUSH = 1;
localparam int F_STAT = 0;

localparam int NUM_ROWS = 23;
localparam logic [4:0] NO_PAIR = 5'd31;

typedef struct packed {
    alu_op_e    op;
    tag_t       dst;
    operand_t   src1;
    operand_t   src2;
    logic [3:0] flags;
    // occupancy the status read should return
    logic [3:0] stat_val;
    // older row that shares the same broadcast on a lower lane
    logic [4:0] pair_row;
    data_t      expected;
} vector_t;

// op, dst, src1 {ready, tag, value}, src2, flags, occupancy, pair, result
vector_t vectors [NUM_ROWS] = '{
    '{ALU_ADD, 4'd0,  21'h1_0_1234, 21'h1_0_0f0f, 4'b1100, 4'd0, NO_PAIR, 16'h2143},
    '{ALU_SUB, 4'd1,  21'h1_0_1000, 21'h1_0_0001, 4'b1100, 4'd0, NO_PAIR, 16'h0fff},
    '{ALU_AND, 4'd2,  21'h1_0_f0f0, 21'h1_0_3c3c, 4'b1100, 4'd0, NO_PAIR, 16'h3030},
    '{ALU_OR,  4'd3,  21'h1_0_0a00, 21'h1_0_00b0, 4'b1100, 4'd0, NO_PAIR, 16'h0ab0},
    '{ALU_XOR, 4'd4,  21'h1_0_ffff, 21'h1_0_1234, 4'b1100, 4'd0, NO_PAIR, 16'hedcb},
    '{ALU_SLL, 4'd5,  21'h1_0_0003, 21'h1_0_0024, 4'b1100, 4'd0, NO_PAIR, 16'h0030},
    // chain with the root dispatched last
    '{ALU_ADD, 4'd6,  21'h0_9_dead, 21'h1_0_0001, 4'b1100, 4'd0, NO_PAIR, 16'h0121},
    '{ALU_SUB, 4'd7,  21'h0_6_dead, 21'h1_0_0010, 4'b1100, 4'd0, NO_PAIR, 16'h0111},
    '{ALU_XOR, 4'd8,  21'h1_0_00ff, 21'h0_7_dead, 4'b1100, 4'd0, NO_PAIR, 16'h01ee},
    '{ALU_OR,  4'd9,  21'h1_0_0100, 21'h1_0_0020, 4'b1100, 4'd0, NO_PAIR, 16'h0120},
    // two waiters on tag 12
    '{ALU_AND, 4'd10, 21'h0_c_dead, 21'h1_0_00ff, 4'b1100, 4'd0, NO_PAIR, 16'h0007},
    '{ALU_SLL, 4'd11, 21'h1_0_0001, 21'h0_c_dead, 4'b1100, 4'd0, 5'd10,   16'h0080},
    '{ALU_ADD, 4'd12, 21'h1_0_0305, 21'h1_0_0002, 4'b1100, 4'd0, NO_PAIR, 16'h0307},
    // tag 15 is produced only after the flush
    '{ALU_ADD, 4'd0,  21'h0_f_dead, 21'h1_0_0000, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_ADD, 4'd1,  21'h0_f_dead, 21'h1_0_0001, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_SUB, 4'd2,  21'h0_f_dead, 21'h1_0_0002, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_AND, 4'd3,  21'h0_f_dead, 21'h1_0_0003, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_OR,  4'd4,  21'h0_f_dead, 21'h1_0_0004, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_XOR, 4'd5,  21'h0_f_dead, 21'h1_0_0005, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_SLL, 4'd6,  21'h0_f_dead, 21'h1_0_0006, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_ADD, 4'd7,  21'h0_f_dead, 21'h1_0_0007, 4'b1000, 4'd0, NO_PAIR, 16'h0000},
    '{ALU_ADD, 4'd14, 21'h0_f_dead, 21'h1_0_0001, 4'b0011, 4'd8, NO_PAIR, 16'h0000},
    '{ALU_XOR, 4'd15, 21'h1_0_5a5a, 21'h1_0_0f0f, 4'b1100, 4'd0, NO_PAIR, 16'h5555}
};

string names [NUM_ROWS] = '{
    "add_ready", "sub_ready", "and_ready", "or_ready", "xor_ready", "sll_ready",
    "chain_a", "chain_b", "chain_c", "chain_root",
    "age_old", "age_young", "age_root",
    "bp_wait0", "bp_wait1", "bp_wait2", "bp_wait3",
    "bp_wait4", "bp_wait5", "bp_wait6", "bp_wait7",
    "bp_blocked", "post_flush"
};

`endif

// ==== tb/issue_cluster_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_cluster_tb;
    import iq_pkg::*;

    localparam int QUEUE_LEN = DEF_QUEUE_LEN;
    localparam int ISSUE_WIDTH = DEF_ISSUE_WIDTH;
    localparam int OCC_W = $clog2(QUEUE_LEN + 1);

    `include "issue_cluster_vectors.svh"

    localparam int MAX_CYCLES = NUM_ROWS * 40 + 100;

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [1:0]              wb_adr;
    logic [31:0]             wb_dat_w;
    logic [31:0]             wb_dat_r;
    logic                    wb_ack;
    logic                    full;
    logic [ISSUE_WIDTH-1:0]  done_valid;
    tag_t [ISSUE_WIDTH-1:0]  done_tag;
    data_t [ISSUE_WIDTH-1:0] done_data;

    integer seed;
    int     cycles = 0;
    int     row_of_tag [16];
    logic   row_done [NUM_ROWS];
    logic   model_known [NUM_ROWS];
    data_t  model [NUM_ROWS];

    issue_cluster #(.QUEUE_LEN(QUEUE_LEN), .ISSUE_WIDTH(ISSUE_WIDTH)) issue_cluster_i (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [OCC_W-1:0] exp,
                               input logic [OCC_W-1:0] act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_failure($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ALU rules with the shift amount from the low nibble of b
    function automatic data_t expected_alu(alu_op_e op, data_t a, data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[3:0];
            default: return 16'h0000;
        endcase
    endfunction

    // source value taken from the producing row once known
    function automatic logic source_value(input operand_t src, output data_t val);
        val = src.value;
        if (src.ready) begin
            return 1'b1;
        end
        for (int j = 0; j < NUM_ROWS; j++) begin
            if (vectors[j].flags[F_DONE] && vectors[j].dst == src.tag && model_known[j]) begin
                val = model[j];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic build_model();
        data_t a;
        data_t b;
        repeat (NUM_ROWS) begin
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (vectors[i].flags[F_DONE] && !model_known[i]
                    && source_value(vectors[i].src1, a) && source_value(vectors[i].src2, b)) begin
                    model[i] = expected_alu(vectors[i].op, a, b);
                    model_known[i] = 1'b1;
                    check_data({names[i], " table"}, vectors[i].expected, model[i]);
                end
            end
        end
    endtask

    task automatic wb_transfer(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                               input int max_wait, output logic acked,
                               output logic [31:0] rdata);
        int idle;
        int waited;
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) @(posedge clk);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= dat;
        acked = 1'b0;
        rdata = 32'd0;
        waited = 0;
        while (!acked && waited < max_wait) begin
            @(negedge clk);
            if (wb_ack) begin
                acked = 1'b1;
                rdata = wb_dat_r;
            end
            waited++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_write(input string name, input logic [1:0] adr, input logic [31:0] dat);
        logic        ok;
        logic [31:0] rd;
        wb_transfer(1'b1, adr, dat, 20, ok, rd);
        if (!ok) begin
            report_failure($sformatf("write to address %0d in %s was never acknowledged",
                                     adr, name));
        end
    endtask

    task automatic read_status(input string name, input int exp_occ);
        logic        ok;
        logic [31:0] rd;
        wb_transfer(1'b0, 2'd3, 32'd0, 20, ok, rd);
        if (!ok) begin
            report_failure($sformatf("status read in %s was never acknowledged", name));
        end
        check_count(name, OCC_W'(exp_occ), rd[OCC_W-1:0]);
        @(negedge clk);
        check_flag({name, " full"}, exp_occ == QUEUE_LEN, full);
    endtask

    function automatic int first_missing();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (vectors[i].flags[F_DONE] && !row_done[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // completion monitor matching every result to its dispatched row
    always @(negedge clk) begin
        int r;
        int p;
        if (rst_n) begin
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (done_valid[l]) begin
                    r = row_of_tag[done_tag[l]];
                    if (r < 0 || !vectors[r].flags[F_DONE] || row_done[r]) begin
                        report_failure($sformatf("tag %0d completed with no instruction for it",
                                                 done_tag[l]));
                    end
                    check_data(names[r], model[r], done_data[l]);
                    if (vectors[r].pair_row != NO_PAIR) begin
                        p = int'(vectors[r].pair_row);
                        if (l == 0 || !done_valid[0]) begin
                            report_failure($sformatf("%s did not complete beside %s",
                                                     names[r], names[p]));
                        end
                        check_tag({names[r], " older lane"}, vectors[p].dst, done_tag[0]);
                    end
                    row_done[r] = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        logic        ok;
        logic [31:0] rd;
        vector_t     v;
        int          waited;
        seed = 32'h5be2;
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 2'd0;
        wb_dat_w = 32'd0;
        for (int t = 0; t < 16; t++) begin
            row_of_tag[t] = -1;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_done[i] = 1'b0;
            model_known[i] = 1'b0;
        end
        build_model();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            v = vectors[i];
            wb_write(names[i], 2'd0, {11'd0, v.src1});
            wb_write(names[i], 2'd1, {11'd0, v.src2});
            row_of_tag[v.dst] = i;
            wb_transfer(1'b1, 2'd2, {25'd0, v.op, v.dst}, 20, ok, rd);
            if (v.flags[F_ACK] && !ok) begin
                report_failure($sformatf("command write of %s was never acknowledged", names[i]));
            end
            if (!v.flags[F_ACK] && ok) begin
                report_failure($sformatf("command write of %s was taken by a full queue",
                                         names[i]));
            end
            if (v.flags[F_STAT]) begin
                read_status(names[i], int'(v.stat_val));
            end
            if (v.flags[F_FLUSH]) begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
                read_status({names[i], " after flush"}, 0);
            end
        end

        // drain and watch for stray flushed tags
        waited = 0;
        while (first_missing() >= 0 && waited < 60) begin
            @(negedge clk);
            waited++;
        end
        if (first_missing() >= 0) begin
            report_failure($sformatf("result of %s never arrived", names[first_missing()]));
        end else begin
            repeat (10) @(negedge clk);
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tb
rtl/iq_pkg.sv
rtl/issue_if.sv
rtl/dispatch_wb.sv
rtl/issue_queue.sv
rtl/alu_lanes.sv
rtl/issue_cluster.sv
tb/issue_cluster_tb.sv

// ==== Bender.yml ====
package:
  name: issue_cluster

sources:
  - rtl/iq_pkg.sv
  - rtl/issue_if.sv
  - rtl/dispatch_wb.sv
  - rtl/issue_queue.sv
  - rtl/alu_lanes.sv
  - rtl/issue_cluster.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/issue_cluster_tb.sv
